// File: all.f
+incdir+test
verilog/gnn_pkg.sv
verilog/weight_bank.sv
verilog/sparse_row_pe.sv
verilog/row_sequencer.sv
verilog/gnn_row_top.sv
test/tb_gnn_row.sv

// File: run.sh
#!/bin/sh
# compile and run the gnn row testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_gnn_row -f all.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vtb_gnn_row
if [ $? -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi

exit 0

// File: test/tb_gnn_ref.svh
`ifndef TB_GNN_REF_SVH
`define TB_GNN_REF_SVH

// anything above the limit is clamped to it
function automatic int sat_mul(input int a, input int b);
  int p;
  p = a * b;
  if (p > int'(DATA_MAX)) begin
    p = int'(DATA_MAX);
  end
  return p;
endfunction

function automatic int sat_add(input int a, input int b);
  int s;
  s = a + b;
  if (s > int'(DATA_MAX)) begin
    s = int'(DATA_MAX);
  end
  return s;
endfunction

// expected result of one row against one weight column
function automatic int expected_dot(
  input idx_vec_t  idx,
  input data_vec_t val,
  input int        nnz,
  input data_vec_t w
);
  int slot [0:DOT_LEN-1];
  int n;
  for (int s = 0; s < DOT_LEN; s++) begin
    slot[s] = 0;
  end
  // pairs in order, so a repeated index keeps the last product
  for (int p = 0; p < nnz; p++) begin
    slot[idx[p]] = sat_mul(int'(val[p]), int'(w[idx[p]]));
  end
  // tree order: slot k takes 2k and 2k+1 on each level
  n = int'(DOT_LEN);
  while (n > 1) begin
    for (int k = 0; k < n / 2; k++) begin
      slot[k] = sat_add(slot[2*k], slot[2*k+1]);
    end
    n = n / 2;
  end
  return slot[0];
endfunction

`endif

// File: test/tb_gnn_row.sv
`default_nettype none

module tb_gnn_row;
  import gnn_pkg::*;

  typedef logic [DOT_LEN-1:0][IDX_W-1:0]  idx_vec_t;
  typedef logic [DOT_LEN-1:0][DATA_W-1:0] data_vec_t;

  `include "tb_gnn_ref.svh"

  localparam int SEED      = 32'hb777;
  localparam int RAND_ROWS = 40;
  // rows take under 30 cycles, a weight write under 4, plus margin
  localparam int MAX_CYCLES = (RAND_ROWS + 12) * 30 + 4 * 32 * 4 + 200;

  logic              clk;
  logic              rst_n;
  logic              wr_en;
  logic [COL_W-1:0]  wr_col;
  logic [IDX_W-1:0]  wr_idx;
  logic [DATA_W-1:0] wr_data;
  logic              row_valid;
  logic [IDX_W-1:0]  row_idx [0:DOT_LEN-1];
  logic [DATA_W-1:0] row_val [0:DOT_LEN-1];
  logic [NNZ_W-1:0]  row_nnz;
  logic              out_valid;
  logic [COL_W-1:0]  out_col;
  logic [DATA_W-1:0] out_data;
  logic              busy;

  // model copy of the weights and the row in flight
  data_vec_t        w_model [0:NUM_COLS-1];
  idx_vec_t         cur_idx;
  data_vec_t        cur_val;
  logic [NNZ_W-1:0] cur_nnz;
  int               accept_cycle;
  int               cycles = 0;
  int               rows_sent = 0;
  int               results_seen = 0;

  gnn_row_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en_i     (wr_en),
    .wr_col_i    (wr_col),
    .wr_idx_i    (wr_idx),
    .wr_data_i   (wr_data),
    .row_valid_i (row_valid),
    .row_idx_i   (row_idx),
    .row_val_i   (row_val),
    .row_nnz_i   (row_nnz),
    .out_valid_o (out_valid),
    .out_col_o   (out_col),
    .out_data_o  (out_data),
    .busy_o      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input int got, input int exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // outputs are sampled on the falling edge
  task automatic wait_idle();
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
  endtask

  task automatic write_weight(
    input logic [COL_W-1:0]  c,
    input logic [IDX_W-1:0]  e,
    input logic [DATA_W-1:0] d
  );
    wait_idle();
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_col  <= c;
    wr_idx  <= e;
    wr_data <= d;
    w_model[c][e] = d;
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  // mode 0 small ramp, 1 large values, else full random
  task automatic load_matrix(input int mode);
    logic [DATA_W-1:0] d;
    for (int c = 0; c < NUM_COLS; c++) begin
      for (int e = 0; e < DOT_LEN; e++) begin
        case (mode)
          0:       d = DATA_W'(c + e + 1);
          1:       d = DATA_W'(128 + ($urandom % 128));
          default: d = DATA_W'($urandom);
        endcase
        write_weight(COL_W'(c), IDX_W'(e), d);
      end
    end
  endtask

  task automatic send_row(input idx_vec_t idx, input data_vec_t val, input int nnz);
    wait_idle();
    // driven after the next edge, captured one edge later
    accept_cycle = cycles + 2;
    cur_idx = idx;
    cur_val = val;
    cur_nnz = NNZ_W'(nnz);
    @(posedge clk);
    row_valid <= 1'b1;
    for (int p = 0; p < DOT_LEN; p++) begin
      row_idx[p] <= idx[p];
      row_val[p] <= val[p];
    end
    row_nnz <= NNZ_W'(nnz);
    @(posedge clk);
    row_valid <= 1'b0;
    rows_sent++;
  endtask

  // entries at and above nnz are junk too
  task automatic send_random_row(input int nnz, input int max_val);
    idx_vec_t  idx;
    data_vec_t val;
    for (int p = 0; p < DOT_LEN; p++) begin
      idx[p] = IDX_W'($urandom % DOT_LEN);
      val[p] = DATA_W'($urandom % (max_val + 1));
    end
    send_row(idx, val, nnz);
  endtask

  initial begin : compare_results
    int  exp_col;
    logic idle_due;
    exp_col  = 0;
    idle_due = 1'b0;
    forever begin
      @(negedge clk);
      if (idle_due) begin
        check_value("busy_o", int'(busy), 0);
        idle_due = 1'b0;
      end
      if (out_valid) begin
        check_value("out_col_o", int'(out_col), exp_col);
        check_value("out_data_o", int'(out_data),
                    expected_dot(cur_idx, cur_val, int'(cur_nnz), w_model[exp_col]));
        check_value("out_valid_o cycle", cycles - accept_cycle, 5 * (exp_col + 1));
        check_value("busy_o", int'(busy), 1);
        idle_due = (exp_col == int'(NUM_COLS) - 1);
        exp_col  = (exp_col + 1) % int'(NUM_COLS);
        results_seen++;
      end
    end
  end

  initial begin : stimulus
    idx_vec_t  idx;
    data_vec_t val;
    void'($urandom(SEED));
    rst_n     <= 1'b0;
    wr_en     <= 1'b0;
    wr_col    <= '0;
    wr_idx    <= '0;
    wr_data   <= '0;
    row_valid <= 1'b0;
    row_nnz   <= '0;
    for (int p = 0; p < DOT_LEN; p++) begin
      row_idx[p] <= '0;
      row_val[p] <= '0;
    end
    for (int c = 0; c < NUM_COLS; c++) begin
      w_model[c] = '0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("busy_o", int'(busy), 0);
    check_value("out_valid_o", int'(out_valid), 0);

    // dense row, distinct indices, sums stay exact
    load_matrix(0);
    for (int p = 0; p < DOT_LEN; p++) begin
      idx[p] = IDX_W'(7 - p);
      val[p] = DATA_W'((p % 2) + 1);
    end
    send_row(idx, val, 8);

    // index 1 and 6 repeat, only the later pair counts
    // small values keep every sum below the clamp
    idx = {3'd7, 3'd0, 3'd6, 3'd6, 3'd6, 3'd4, 3'd1, 3'd1};
    for (int p = 0; p < DOT_LEN; p++) begin
      val[p] = DATA_W'(p + 1);
    end
    send_row(idx, val, 8);

    send_random_row(0, 20);
    send_random_row(1, 20);
    send_random_row(5, 20);

    // new weights on two columns, then the dense row again
    for (int e = 0; e < DOT_LEN; e++) begin
      write_weight(COL_W'(1), IDX_W'(e), DATA_W'(20 - e));
      write_weight(COL_W'(2), IDX_W'(e), DATA_W'(3 * e));
    end
    for (int p = 0; p < DOT_LEN; p++) begin
      idx[p] = IDX_W'(7 - p);
      val[p] = DATA_W'((p % 2) + 1);
    end
    send_row(idx, val, 8);

    // large operands push products and partial sums past the limit
    load_matrix(1);
    send_random_row(8, 255);
    send_random_row(3, 255);
    for (int p = 0; p < DOT_LEN; p++) begin
      idx[p] = IDX_W'(p);
      val[p] = 8'd1;
    end
    send_row(idx, val, 8);

    load_matrix(2);
    for (int r = 0; r < RAND_ROWS; r++) begin
      if (r % 10 == 9) begin
        for (int k = 0; k < 4; k++) begin
          write_weight(COL_W'($urandom % NUM_COLS), IDX_W'($urandom % DOT_LEN),
                       DATA_W'($urandom));
        end
      end
      send_random_row(int'($urandom % (DOT_LEN + 1)), 255);
    end

    wait_idle();
    repeat (2) @(negedge clk);
    if (results_seen != rows_sent * int'(NUM_COLS)) begin
      $display("saw %0d results for %0d rows", results_seen, rows_sent);
      $display("TESTBENCH FAILED");
      $fatal(1, "results missing");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog/gnn_row_top.sv
`default_nettype none

module gnn_row_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // weight load
  input  logic                        wr_en_i,
  input  logic [gnn_pkg::COL_W-1:0]   wr_col_i,
  input  logic [gnn_pkg::IDX_W-1:0]   wr_idx_i,
  input  logic [gnn_pkg::DATA_W-1:0]  wr_data_i,
  // sparse row
  input  logic                        row_valid_i,
  input  logic [gnn_pkg::IDX_W-1:0]   row_idx_i  [0:gnn_pkg::DOT_LEN-1],
  input  logic [gnn_pkg::DATA_W-1:0]  row_val_i  [0:gnn_pkg::DOT_LEN-1],
  input  logic [gnn_pkg::NNZ_W-1:0]   row_nnz_i,
  // results, one per column
  output logic                        out_valid_o,
  output logic [gnn_pkg::COL_W-1:0]   out_col_o,
  output logic [gnn_pkg::DATA_W-1:0]  out_data_o,
  output logic                        busy_o
);
  import gnn_pkg::*;

  logic [DATA_W-1:0] col_weights [0:DOT_LEN-1];
  logic [COL_W-1:0]  cur_col;
  logic              pe_start;
  logic [IDX_W-1:0]  pe_idx [0:DOT_LEN-1];
  logic [DATA_W-1:0] pe_val [0:DOT_LEN-1];
  logic [NNZ_W-1:0]  pe_nnz;
  logic [DATA_W-1:0] pe_result;
  logic              pe_done;

  weight_bank u_weight_bank (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_en_i      (wr_en_i),
    .wr_col_i     (wr_col_i),
    .wr_idx_i     (wr_idx_i),
    .wr_data_i    (wr_data_i),
    .rd_col_i     (cur_col),
    .rd_weights_o (col_weights),
    .busy_i       (busy_o)
  );

  row_sequencer u_row_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .row_valid_i (row_valid_i),
    .row_idx_i   (row_idx_i),
    .row_val_i   (row_val_i),
    .row_nnz_i   (row_nnz_i),
    .pe_done_i   (pe_done),
    .pe_result_i (pe_result),
    .pe_start_o  (pe_start),
    .pe_idx_o    (pe_idx),
    .pe_val_o    (pe_val),
    .pe_nnz_o    (pe_nnz),
    .col_o       (cur_col),
    .out_valid_o (out_valid_o),
    .out_col_o   (out_col_o),
    .out_data_o  (out_data_o),
    .busy_o      (busy_o)
  );

  sparse_row_pe u_sparse_row_pe (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (pe_start),
    .idx_i     (pe_idx),
    .val_i     (pe_val),
    .nnz_i     (pe_nnz),
    .weights_i (col_weights),
    .result_o  (pe_result),
    .done_o    (pe_done)
  );

endmodule

`default_nettype wire

// File: verilog/row_sequencer.sv
`default_nettype none

module row_sequencer (
  input  logic                        clk,
  input  logic                        rst_n,
  // row from the host
  input  logic                        row_valid_i,
  input  logic [gnn_pkg::IDX_W-1:0]   row_idx_i  [0:gnn_pkg::DOT_LEN-1],
  input  logic [gnn_pkg::DATA_W-1:0]  row_val_i  [0:gnn_pkg::DOT_LEN-1],
  input  logic [gnn_pkg::NNZ_W-1:0]   row_nnz_i,
  // element handshake
  input  logic                        pe_done_i,
  input  logic [gnn_pkg::DATA_W-1:0]  pe_result_i,
  output logic                        pe_start_o,
  output logic [gnn_pkg::IDX_W-1:0]   pe_idx_o   [0:gnn_pkg::DOT_LEN-1],
  output logic [gnn_pkg::DATA_W-1:0]  pe_val_o   [0:gnn_pkg::DOT_LEN-1],
  output logic [gnn_pkg::NNZ_W-1:0]   pe_nnz_o,
  // column select to the weight bank
  output logic [gnn_pkg::COL_W-1:0]   col_o,
  // tagged results
  output logic                        out_valid_o,
  output logic [gnn_pkg::COL_W-1:0]   out_col_o,
  output logic [gnn_pkg::DATA_W-1:0]  out_data_o,
  output logic                        busy_o
);
  import gnn_pkg::*;

  seq_state_e        state_q;
  logic [COL_W-1:0]  col_q;
  logic              step;
  logic              last_col;

  // held row
  logic [IDX_W-1:0]  row_idx_q [0:DOT_LEN-1];
  logic [DATA_W-1:0] row_val_q [0:DOT_LEN-1];
  logic [NNZ_W-1:0]  row_nnz_q;

  // a result comes back for col_q
  assign step     = (state_q == SEQ_WAIT) && pe_done_i;
  assign last_col = (col_q == COL_W'(NUM_COLS - 1));

  // next start overlaps the done cycle, so the bank already sees the next column
  assign pe_start_o = (state_q == SEQ_START) || (step && !last_col);
  assign col_o      = step ? col_q + COL_W'(1) : col_q;

  assign out_valid_o = step;
  assign out_col_o   = col_q;
  assign out_data_o  = pe_result_i;
  assign busy_o      = (state_q != SEQ_IDLE);

  assign pe_idx_o = row_idx_q;
  assign pe_val_o = row_val_q;
  assign pe_nnz_o = row_nnz_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= SEQ_IDLE;
      col_q   <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          if (row_valid_i) begin
            col_q   <= '0;
            state_q <= SEQ_START;
          end
        end
        SEQ_START: begin
          state_q <= SEQ_WAIT;
        end
        SEQ_WAIT: begin
          if (pe_done_i) begin
            col_q <= col_q + COL_W'(1);
            if (last_col) begin
              state_q <= SEQ_IDLE;
            end
          end
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  // capture the row on accept
  always_ff @(posedge clk) begin
    if ((state_q == SEQ_IDLE) && row_valid_i) begin
      for (int p = 0; p < DOT_LEN; p++) begin
        row_idx_q[p] <= row_idx_i[p];
        row_val_q[p] <= row_val_i[p];
      end
      row_nnz_q <= row_nnz_i;
    end
  end

  // host waits for busy to drop before the next row
  a_no_row_when_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    busy_o |-> !row_valid_i
  ) else $error("row offered while busy");

endmodule

`default_nettype wire

// File: verilog/sparse_row_pe.sv
`default_nettype none

module sparse_row_pe (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start_i,
  // compressed feature row
  input  logic [gnn_pkg::IDX_W-1:0]   idx_i     [0:gnn_pkg::DOT_LEN-1],
  input  logic [gnn_pkg::DATA_W-1:0]  val_i     [0:gnn_pkg::DOT_LEN-1],
  input  logic [gnn_pkg::NNZ_W-1:0]   nnz_i,
  // dense weight column
  input  logic [gnn_pkg::DATA_W-1:0]  weights_i [0:gnn_pkg::DOT_LEN-1],
  output logic [gnn_pkg::DATA_W-1:0]  result_o,
  output logic                        done_o
);
  import gnn_pkg::*;

  pe_state_e         state_q;
  logic [LVL_W-1:0]  lvl_q;
  logic              accept;
  logic              done_q;
  logic [DATA_W-1:0] result_q;

  // products as gathered, then the working slots of the tree
  logic [DATA_W-1:0] prod_d [0:DOT_LEN-1];
  logic [DATA_W-1:0] slot_q [0:DOT_LEN-1];

  // clamped multiply
  function automatic logic [DATA_W-1:0] sat_mul(
    input logic [DATA_W-1:0] a,
    input logic [DATA_W-1:0] b
  );
    logic [2*DATA_W-1:0] full;
    full = a * b;
    if (full > (2*DATA_W)'(DATA_MAX)) begin
      return DATA_W'(DATA_MAX);
    end
    return full[DATA_W-1:0];
  endfunction

  // clamped add
  function automatic logic [DATA_W-1:0] sat_add(
    input logic [DATA_W-1:0] a,
    input logic [DATA_W-1:0] b
  );
    logic [DATA_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    if (sum > (DATA_W+1)'(DATA_MAX)) begin
      return DATA_W'(DATA_MAX);
    end
    return sum[DATA_W-1:0];
  endfunction

  assign accept = start_i && (state_q == PE_IDLE);

  // gather: each valid pair lands in the slot named by its index
  // later pairs overwrite earlier ones on a repeated index
  always_comb begin
    for (int s = 0; s < DOT_LEN; s++) begin
      prod_d[s] = '0;
    end
    for (int p = 0; p < DOT_LEN; p++) begin
      if (NNZ_W'(p) < nnz_i) begin
        prod_d[idx_i[p]] = sat_mul(val_i[p], weights_i[idx_i[p]]);
      end
    end
  end

  // control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= PE_IDLE;
      lvl_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        PE_IDLE: begin
          if (accept) begin
            state_q <= PE_REDUCE;
            lvl_q   <= '0;
          end
        end
        PE_REDUCE: begin
          lvl_q <= lvl_q + LVL_W'(1);
          // last tree level registers on this edge
          if (lvl_q == LVL_W'(TREE_LEVELS - 1)) begin
            state_q <= PE_DONE;
          end
        end
        PE_DONE: begin
          done_q  <= 1'b1;
          state_q <= PE_IDLE;
        end
        default: begin
          state_q <= PE_IDLE;
        end
      endcase
    end
  end

  // products in, then halve in place: slot k takes 2k and 2k+1
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int s = 0; s < DOT_LEN; s++) begin
        slot_q[s] <= prod_d[s];
      end
    end else if (state_q == PE_REDUCE) begin
      for (int k = 0; k < DOT_LEN / 2; k++) begin
        slot_q[k] <= sat_add(slot_q[2*k], slot_q[2*k+1]);
      end
    end
  end

  // slot 0 holds the full sum once the tree is done
  always_ff @(posedge clk) begin
    if (state_q == PE_DONE) begin
      result_q <= slot_q[0];
    end
  end

  assign result_o = result_q;
  assign done_o   = done_q;

  // sequencer may only start an idle element
  a_start_only_idle : assert property (
    @(posedge clk) disable iff (!rst_n)
    start_i |-> (state_q == PE_IDLE)
  ) else $error("start while the element is busy");

  // done is sampled high on the fifth edge after accept, for one cycle only
  a_done_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    accept |-> ##5 done_o ##1 !done_o
  ) else $error("done timing broken");

endmodule

`default_nettype wire

// File: verilog/weight_bank.sv
`default_nettype none

module weight_bank (
  input  logic                        clk,
  input  logic                        rst_n,
  // host write port
  input  logic                        wr_en_i,
  input  logic [gnn_pkg::COL_W-1:0]   wr_col_i,
  input  logic [gnn_pkg::IDX_W-1:0]   wr_idx_i,
  input  logic [gnn_pkg::DATA_W-1:0]  wr_data_i,
  // column read for the element
  input  logic [gnn_pkg::COL_W-1:0]   rd_col_i,
  output logic [gnn_pkg::DATA_W-1:0]  rd_weights_o [0:gnn_pkg::DOT_LEN-1],
  // row in progress
  input  logic                        busy_i
);
  import gnn_pkg::*;

  // weight matrix, indexed [column][entry]
  logic [DATA_W-1:0] w_q [0:NUM_COLS-1][0:DOT_LEN-1];

  // one byte per write strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        for (int e = 0; e < DOT_LEN; e++) begin
          w_q[c][e] <= '0;
        end
      end
    end else if (wr_en_i) begin
      w_q[wr_col_i][wr_idx_i] <= wr_data_i;
    end
  end

  // whole column at once so the element can gather any index
  always_comb begin
    for (int e = 0; e < DOT_LEN; e++) begin
      rd_weights_o[e] = w_q[rd_col_i][e];
    end
  end

  // weights must hold still while a row is being worked on
  a_no_write_when_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    busy_i |-> !wr_en_i
  ) else $error("weight write while a row is in flight");

endmodule

`default_nettype wire

// File: verilog/gnn_pkg.sv
`default_nettype none

package gnn_pkg;

  // value, weight and result width
  localparam int unsigned DATA_W = 8;

  // entries per weight column, also the widest row
  localparam int unsigned DOT_LEN = 8;
  localparam int unsigned IDX_W = $clog2(DOT_LEN);

  // pair count runs 0..DOT_LEN, so one extra bit
  localparam int unsigned NNZ_W = $clog2(DOT_LEN) + 1;

  // weight matrix shape
  localparam int unsigned NUM_COLS = 4;
  localparam int unsigned COL_W = $clog2(NUM_COLS);

  // pairwise reduction depth and its counter width
  localparam int unsigned TREE_LEVELS = $clog2(DOT_LEN);
  localparam int unsigned LVL_W = $clog2(TREE_LEVELS);

  // clamp value for products and partial sums
  localparam int unsigned DATA_MAX = (1 << DATA_W) - 1;

  // processing element control
  typedef enum logic [1:0] {
    PE_IDLE,
    PE_REDUCE,
    PE_DONE
  } pe_state_e;

  // row sequencer control
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_START,
    SEQ_WAIT
  } seq_state_e;

endpackage

`default_nettype wire
